//--- bus_arbiter.sv
// Fixed priority bus arbiter, keyboard over host, with steering of the
// owner's lines onto the shared bus
`timescale 1ns/1ps

module bus_arbiter (
   input  logic            bus_clk,
   input  logic            rst_n,
   input  logic            kbd_br,
   input  logic            host_br,
   input  bus_pkg::addr_t  kbd_a,
   input  bus_pkg::data_t  kbd_wdata,
   input  logic            kbd_valid,
   input  bus_pkg::addr_t  host_a,
   input  logic            host_valid,
   output logic            kbd_bg,
   output logic            host_bg,
   output bus_pkg::addr_t  bus_a,
   output bus_pkg::data_t  bus_wdata,
   output logic            bus_rw,
   output logic            bus_valid
);

   // Owner bits, bit 0 keyboard, bit 1 host, at most one set
   logic [1:0] owner;

   assign kbd_bg  = owner[0];
   assign host_bg = owner[1];

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         owner <= 2'b00;
      else if (owner == 2'b00)
      begin
         // Free bus, keyboard wins a tie
         if (kbd_br)
            owner <= 2'b01;
         else if (host_br)
            owner <= 2'b10;
      end
      // Grant only ends when its request drops
      else if (owner[0] && !kbd_br)
         owner <= 2'b00;
      else if (owner[1] && !host_br)
         owner <= 2'b00;
   end

   // Keyboard only writes, host port only reads
   assign bus_rw = owner[0];

   always_comb
   begin
      bus_a     = '0;
      bus_wdata = '0;
      bus_valid = 1'b0;
      if (owner[0])
      begin
         bus_a     = kbd_a;
         bus_wdata = kbd_wdata;
         bus_valid = kbd_valid;
      end
      else if (owner[1])
      begin
         bus_a     = host_a;
         bus_valid = host_valid;
      end
   end

endmodule

//--- bus_pkg.sv
// Shared bus types, controller state encoding and memory map constants
// for the keyboard bus subsystem

package bus_pkg;

   // Byte address on the system bus
   typedef logic [15:0] addr_t;

   // One bus data beat
   typedef logic [31:0] data_t;

   // Remaining transfer size in bytes
   typedef logic [11:0] size_t;

   // Raw key code from the scanner
   typedef logic [7:0] key_t;

   // Sequence stamp given to each accepted key
   typedef logic [7:0] seq_t;

   // Keyboard controller states
   // Only the master write path is kept, the device is never read
   typedef enum logic [1:0] {
      idle,
      st_br,
      mstr,
      st_wr
   } ctrl_state_t;

   // Start of the keyboard record ring in RAM
   localparam addr_t KBD_BASE = 16'h7000;

   // One key record is four beats long
   localparam size_t RECORD_BYTES = 12'd16;

   // Bytes moved per acknowledged beat
   localparam size_t BEAT_BYTES = 12'd4;

endpackage

//--- kbd_bus_checker.sv
// Keyboard bus checker with key queue model, record ring model,
// reference record words and compare of drops and host reads
`timescale 1ns/1ps

module kbd_bus_checker #(
   parameter int KBD_SLOTS   = 4,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic           bus_clk,
   input  logic           rst_n,
   input  logic           key_valid,
   input  bus_pkg::key_t  key_code,
   input  logic           key_drop,
   input  logic           kbd_done,
   input  logic           host_bg,
   input  logic           host_valid,
   input  bus_pkg::addr_t host_a,
   input  logic           bus_ack,
   input  bus_pkg::data_t bus_rdata,
   input  logic [127:0]   test_name,
   output int             err_count,
   output int             read_count,
   output int             done_count
);

   // Waiting keys as {seq, key}
   logic [15:0]    key_q [$];
   logic [15:0]    head;
   bus_pkg::seq_t  seq_ctr;
   logic           full_now;
   logic           drop_exp;
   int             idx;
   int             errs  = 0;
   int             reads = 0;
   int             dones = 0;
   // Expected ring words, keyed by word offset from the ring base
   bus_pkg::data_t ring_mem [int];

   assign err_count  = errs;
   assign read_count = reads;
   assign done_count = dones;

   // Beat number, stamp, spare zero byte, key code
   function automatic bus_pkg::data_t record_word(input int beat, input bus_pkg::seq_t seq,
                                                  input bus_pkg::key_t key);
      return {8'(beat), seq, 8'h00, key};
   endfunction

   always @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         // Queue and stamp restart, RAM keeps its words
         key_q.delete();
         seq_ctr  = '0;
         drop_exp = 1'b0;
      end
      else
      begin
         // key_drop answers the strobe of the edge before
         if (key_drop !== drop_exp)
         begin
            errs++;
            $display("FAIL %0s key_drop expected %b actual %b", test_name, drop_exp, key_drop);
         end
         full_now = (key_q.size() >= QUEUE_DEPTH);
         drop_exp = key_valid && full_now;
         // Finished record pops the oldest key into its ring slot
         if (kbd_done)
         begin
            if (key_q.size() == 0)
            begin
               errs++;
               $display("ERROR %0s: kbd_done pulsed with no key waiting", test_name);
            end
            else
            begin
               head = key_q.pop_front();
               for (int b = 0; b < 4; b++)
                  ring_mem[(int'(head[15:8]) % KBD_SLOTS) * 4 + b] =
                     record_word(b, head[15:8], head[7:0]);
               dones++;
            end
         end
         if (key_valid && !full_now)
         begin
            key_q.push_back({seq_ctr, key_code});
            seq_ctr = seq_ctr + 8'd1;
         end
         // Host read data sits on the bus in the ack cycle
         if (host_bg && host_valid && bus_ack)
         begin
            reads++;
            idx = (int'(host_a) - int'(bus_pkg::KBD_BASE)) / 4;
            if (idx < 0 || idx >= KBD_SLOTS * 4 || !ring_mem.exists(idx))
            begin
               errs++;
               $display("ERROR %0s: host read at %h has no record behind it", test_name, host_a);
            end
            else if (bus_rdata !== ring_mem[idx])
            begin
               errs++;
               $display("FAIL %0s word %h expected %h actual %h", test_name, host_a,
                        ring_mem[idx], bus_rdata);
            end
         end
      end
   end

endmodule

//--- kbd_bus_controller.sv
// Keyboard bus master FSM, writes one 16 byte key record per grant
// as four 32 bit beats
`timescale 1ns/1ps

module kbd_bus_controller #(
   parameter int KBD_SLOTS = 4
) (
   input  logic            bus_clk,
   input  logic            rst_n,
   input  logic            mod_en,
   input  bus_pkg::key_t   head_key,
   input  bus_pkg::seq_t   head_seq,
   input  logic            bg,
   input  logic            bus_ack,
   output logic            br,
   output bus_pkg::addr_t  m_a,
   output bus_pkg::data_t  m_wdata,
   output logic            m_valid,
   output logic            rec_done,
   output logic            kbd_done
);

   bus_pkg::ctrl_state_t state;
   bus_pkg::ctrl_state_t state_next;

   // Bytes still to send in the current record
   bus_pkg::size_t       size;
   // Bytes already sent, so the byte offset inside the record
   bus_pkg::size_t       offset;
   bus_pkg::addr_t       slot_off;
   logic [7:0]           beat_num;
   logic                 last_ack;
   // Done flag, plays the part of the ready register
   logic                 done_r;

   // Final beat of the record has been acknowledged
   assign last_ack = (state == bus_pkg::st_wr) && bus_ack && (size == bus_pkg::BEAT_BYTES);

   // As size counts down the offset into the record goes up
   assign offset   = bus_pkg::RECORD_BYTES - size;
   assign beat_num = 8'(offset / bus_pkg::BEAT_BYTES);

   // Ring slot chosen from the low sequence bits
   assign slot_off = bus_pkg::addr_t'(head_seq % KBD_SLOTS) *
                     bus_pkg::addr_t'(bus_pkg::RECORD_BYTES);

   assign m_a     = bus_pkg::KBD_BASE + slot_off + bus_pkg::addr_t'(offset);
   // Beat number, sequence stamp, spare byte, key code
   assign m_wdata = {beat_num, head_seq, 8'h00, head_key};

   // Request held for the whole transfer
   assign br      = (state != bus_pkg::idle);
   // Lines stay put through the ack cycle, the next beat follows the ack edge
   assign m_valid = (state == bus_pkg::st_wr);

   assign rec_done = done_r;
   assign kbd_done = done_r;

   always_comb
   begin
      state_next = state;
      case (state)
         bus_pkg::idle:
            // Pop of the finished entry lands with done, so skip that cycle
            if (mod_en && !done_r)
               state_next = bus_pkg::st_br;
         bus_pkg::st_br:
            if (bg)
               state_next = bus_pkg::mstr;
         bus_pkg::mstr:
            state_next = bus_pkg::st_wr;
         bus_pkg::st_wr:
            if (last_ack)
               state_next = bus_pkg::idle;
         default:
            state_next = bus_pkg::idle;
      endcase
   end

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state  <= bus_pkg::idle;
         size   <= '0;
         done_r <= 1'b0;
      end
      else
      begin
         state <= state_next;
         // Size loaded once we own the bus, then drops per ack
         if (state == bus_pkg::mstr)
            size <= bus_pkg::RECORD_BYTES;
         else if ((state == bus_pkg::st_wr) && bus_ack)
            size <= size - bus_pkg::BEAT_BYTES;
         // Single pulse when size reaches zero
         done_r <= last_ack;
      end
   end

endmodule

//--- kbd_bus_props.sv
// Bus handshake assertions, bound into the subsystem top
`timescale 1ns/1ps

module kbd_bus_props (
   input logic           bus_clk,
   input logic           rst_n,
   input logic           kbd_br,
   input logic           kbd_bg,
   input logic           host_bg,
   input logic           bus_ack,
   input logic           bus_valid,
   input logic           bus_rw,
   input bus_pkg::addr_t bus_a,
   input bus_pkg::data_t bus_wdata
);

   // One owner at a time
   a_one_owner: assert property (@(posedge bus_clk) disable iff (!rst_n)
      !(kbd_bg && host_bg))
      else $error("bus granted to both masters");

   // Slave needs a quiet cycle between acks
   a_ack_gap: assert property (@(posedge bus_clk) disable iff (!rst_n)
      bus_ack |=> !bus_ack)
      else $error("bus_ack on two cycles in a row");

   a_grant_req: assert property (@(posedge bus_clk) disable iff (!rst_n)
      $rose(kbd_bg) |-> $past(kbd_br))
      else $error("keyboard grant without a request");

   // Beat held unchanged into its ack cycle
   a_beat_hold: assert property (@(posedge bus_clk) disable iff (!rst_n)
      (bus_valid && !bus_ack) |=>
         (bus_valid && $stable(bus_a) && $stable(bus_wdata) && $stable(bus_rw)))
      else $error("bus lines moved while a beat waited for ack");

endmodule

bind kbd_bus_top kbd_bus_props kbd_bus_props_i (
   .bus_clk   (bus_clk),
   .rst_n     (rst_n),
   .kbd_br    (kbd_br),
   .kbd_bg    (kbd_bg),
   .host_bg   (host_bg),
   .bus_ack   (bus_ack),
   .bus_valid (bus_valid),
   .bus_rw    (bus_rw),
   .bus_a     (bus_a),
   .bus_wdata (bus_wdata)
);

//--- kbd_bus_top.sv
// Keyboard bus subsystem top, key queue, bus master, arbiter and RAM
`timescale 1ns/1ps

module kbd_bus_top #(
   parameter int KBD_SLOTS   = 4,
   parameter int RAM_WORDS   = 256,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic            bus_clk,
   input  logic            rst_n,
   input  logic            key_valid,
   input  bus_pkg::key_t   key_code,
   input  logic            host_br,
   input  bus_pkg::addr_t  host_a,
   input  logic            host_valid,
   output logic            host_bg,
   output logic            bus_ack,
   output bus_pkg::data_t  bus_rdata,
   output logic            kbd_done,
   output logic            key_drop
);

   // Queue to controller
   logic            mod_en;
   bus_pkg::key_t   head_key;
   bus_pkg::seq_t   head_seq;
   logic            rec_done;

   // Keyboard master side of the arbiter
   logic            kbd_br;
   logic            kbd_bg;
   bus_pkg::addr_t  kbd_a;
   bus_pkg::data_t  kbd_wdata;
   logic            kbd_valid;

   // Shared bus after steering
   bus_pkg::addr_t  bus_a;
   bus_pkg::data_t  bus_wdata;
   logic            bus_rw;
   logic            bus_valid;

   kbd_scan_buffer #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) kbd_scan_buffer_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .key_valid (key_valid),
      .key_code  (key_code),
      .rec_done  (rec_done),
      .mod_en    (mod_en),
      .head_key  (head_key),
      .head_seq  (head_seq),
      .key_drop  (key_drop)
   );

   kbd_bus_controller #(
      .KBD_SLOTS (KBD_SLOTS)
   ) kbd_bus_controller_i (
      .bus_clk  (bus_clk),
      .rst_n    (rst_n),
      .mod_en   (mod_en),
      .head_key (head_key),
      .head_seq (head_seq),
      .bg       (kbd_bg),
      .bus_ack  (bus_ack),
      .br       (kbd_br),
      .m_a      (kbd_a),
      .m_wdata  (kbd_wdata),
      .m_valid  (kbd_valid),
      .rec_done (rec_done),
      .kbd_done (kbd_done)
   );

   bus_arbiter bus_arbiter_i (
      .bus_clk    (bus_clk),
      .rst_n      (rst_n),
      .kbd_br     (kbd_br),
      .host_br    (host_br),
      .kbd_a      (kbd_a),
      .kbd_wdata  (kbd_wdata),
      .kbd_valid  (kbd_valid),
      .host_a     (host_a),
      .host_valid (host_valid),
      .kbd_bg     (kbd_bg),
      .host_bg    (host_bg),
      .bus_a      (bus_a),
      .bus_wdata  (bus_wdata),
      .bus_rw     (bus_rw),
      .bus_valid  (bus_valid)
   );

   ram_slave #(
      .RAM_WORDS (RAM_WORDS)
   ) ram_slave_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .bus_a     (bus_a),
      .bus_wdata (bus_wdata),
      .bus_rw    (bus_rw),
      .bus_valid (bus_valid),
      .bus_ack   (bus_ack),
      .bus_rdata (bus_rdata)
   );

endmodule

//--- kbd_scan_buffer.sv
// Key code queue between the scanner strobes and the bus controller
`timescale 1ns/1ps

module kbd_scan_buffer #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic            bus_clk,
   input  logic            rst_n,
   input  logic            key_valid,
   input  bus_pkg::key_t   key_code,
   input  logic            rec_done,
   output logic            mod_en,
   output bus_pkg::key_t   head_key,
   output bus_pkg::seq_t   head_seq,
   output logic            key_drop
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   // Entry storage, key and its stamp side by side
   bus_pkg::key_t    key_mem [QUEUE_DEPTH];
   bus_pkg::seq_t    seq_mem [QUEUE_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   bus_pkg::seq_t    next_seq;
   logic             full;
   logic             push;
   logic             pop;

   assign full = (count == CNT_W'(QUEUE_DEPTH));
   // A strobe into a full queue is lost
   assign push = key_valid && !full;
   assign pop  = rec_done && (count != '0);

   // Controller sees work pending as a level
   assign mod_en   = (count != '0);
   assign head_key = key_mem[rd_ptr];
   assign head_seq = seq_mem[rd_ptr];

   // Payload write, stamped with the running sequence number
   always_ff @(posedge bus_clk)
   begin
      if (push)
      begin
         key_mem[wr_ptr] <= key_code;
         seq_mem[wr_ptr] <= next_seq;
      end
   end

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         next_seq <= '0;
         key_drop <= 1'b0;
      end
      else
      begin
         // Pointers wrap on their own since depth is a power of two
         if (push)
         begin
            wr_ptr   <= wr_ptr + 1'b1;
            next_seq <= next_seq + 1'b1;
         end
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Occupancy follows push and pop together
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // One cycle flag for each lost key
         key_drop <= key_valid && full;
      end
   end

endmodule

//--- list.f
bus_pkg.sv
kbd_scan_buffer.sv
kbd_bus_controller.sv
bus_arbiter.sv
ram_slave.sv
kbd_bus_top.sv
kbd_bus_props.sv
kbd_bus_checker.sv
tb_kbd_bus.sv

//--- ram_slave.sv
// Word addressed RAM slave with single cycle registered ack per beat
`timescale 1ns/1ps

module ram_slave #(
   parameter int RAM_WORDS = 256
) (
   input  logic            bus_clk,
   input  logic            rst_n,
   input  bus_pkg::addr_t  bus_a,
   input  bus_pkg::data_t  bus_wdata,
   input  logic            bus_rw,
   input  logic            bus_valid,
   output logic            bus_ack,
   output bus_pkg::data_t  bus_rdata
);

   localparam int IDX_W = $clog2(RAM_WORDS);

   bus_pkg::data_t   mem [RAM_WORDS];

   // Word index from the byte address, wrapped to the array size
   logic [IDX_W-1:0] idx;
   // Beat accepted this edge
   logic             take;

   assign idx = IDX_W'((bus_a >> 2) % RAM_WORDS);

   // No new beat in the ack cycle, the master still shows the old one
   assign take = bus_valid && !bus_ack;

   // Array access on an accepted beat
   always_ff @(posedge bus_clk)
   begin
      if (take)
      begin
         if (bus_rw)
            mem[idx] <= bus_wdata;
         else
            bus_rdata <= mem[idx];
      end
   end

   // Ack follows the sampled beat by one cycle
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
         bus_ack <= 1'b0;
      else
         bus_ack <= take;
   end

endmodule

//--- run.sh
#!/bin/sh
# Build the keyboard bus testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_kbd_bus -o sim_kbd_bus
./obj_dir/sim_kbd_bus > sim.log 2>&1 || true
cat sim.log
if grep -q "^RESULT: PASS$" sim.log; then
   exit 0
fi
exit 1

//--- tb_kbd_bus.sv
// Testbench top for the keyboard bus subsystem
// Clock, reset, key strobes, host reads and the closing report
`timescale 1ns/1ps

module tb_kbd_bus;

   localparam int KBD_SLOTS   = 4;
   localparam int QUEUE_DEPTH = 4;
   localparam int TIMEOUT     = 300;

   logic           bus_clk;
   logic           rst_n;
   logic           key_valid;
   bus_pkg::key_t  key_code;
   logic           host_br;
   bus_pkg::addr_t host_a;
   logic           host_valid;
   logic           host_bg;
   logic           bus_ack;
   bus_pkg::data_t bus_rdata;
   logic           kbd_done;
   logic           key_drop;
   // Label of the running test, the checker prints it too
   logic [127:0]   test_name;
   logic [31:0]    rng;
   int             err_count;
   int             read_count;
   int             done_count;
   int             tb_errors;
   int             reads_issued;
   int             base_dones;
   int             drops;
   int             t;
   logic           seen_done;

   always #50 bus_clk = ~bus_clk;

   kbd_bus_top #(
      .KBD_SLOTS   (KBD_SLOTS),
      .RAM_WORDS   (256),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) kbd_bus_top_i (.*);

   kbd_bus_checker #(
      .KBD_SLOTS   (KBD_SLOTS),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) kbd_bus_checker_i (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic timeout_error(input string what);
      tb_errors++;
      $display("ERROR %0s: timed out waiting for %0s", test_name, what);
   endtask

   task automatic check_bit(input string sig, input logic exp, input logic act);
      if (act !== exp)
      begin
         tb_errors++;
         $display("FAIL %0s %0s expected %b actual %b", test_name, sig, exp, act);
      end
   endtask

   // Outputs that must rest low in and right after reset
   task automatic check_quiet();
      check_bit("host_bg", 1'b0, host_bg);
      check_bit("bus_ack", 1'b0, bus_ack);
      check_bit("kbd_done", 1'b0, kbd_done);
      check_bit("key_drop", 1'b0, key_drop);
   endtask

   // Called on a falling edge, returns on the next one
   task automatic press_key(input bus_pkg::key_t code);
      key_valid = 1'b1;
      key_code  = code;
      @(negedge bus_clk);
      key_valid = 1'b0;
   endtask

   task automatic wait_records(input int target);
      int n;
      n = 0;
      while (done_count < target && n < TIMEOUT)
      begin
         @(negedge bus_clk);
         n++;
      end
      if (done_count < target)
         timeout_error("kbd_done of a key record");
   endtask

   task automatic host_acquire();
      int n;
      n = 0;
      host_br = 1'b1;
      while (!host_bg && n < TIMEOUT)
      begin
         @(negedge bus_clk);
         n++;
      end
      if (!host_bg)
         timeout_error("host_bg");
   endtask

   task automatic host_release();
      host_br    = 1'b0;
      host_valid = 1'b0;
      @(negedge bus_clk);
   endtask

   task automatic read_word(input bus_pkg::addr_t addr);
      int n;
      n = 0;
      host_a     = addr;
      host_valid = 1'b1;
      reads_issued++;
      @(negedge bus_clk);
      while (!bus_ack && n < TIMEOUT)
      begin
         @(negedge bus_clk);
         n++;
      end
      if (!bus_ack)
         timeout_error("bus_ack on a host read");
      // Beat stays on the bus through the ack cycle
      @(negedge bus_clk);
      host_valid = 1'b0;
   endtask

   // Four words per slot, the checker compares each ack
   task automatic read_slots(input int first, input int count);
      for (int s = first; s < first + count; s++)
         for (int b = 0; b < 4; b++)
            read_word(bus_pkg::addr_t'(int'(bus_pkg::KBD_BASE) + s * 16 + b * 4));
   endtask

   initial
   begin
      bus_clk      = 1'b0;
      rst_n        = 1'b0;
      key_valid    = 1'b0;
      key_code     = '0;
      host_br      = 1'b0;
      host_a       = '0;
      host_valid   = 1'b0;
      rng          = 32'h922e;
      tb_errors    = 0;
      reads_issued = 0;
      test_name    = "reset";
      repeat (3) @(posedge bus_clk);
      @(negedge bus_clk);
      check_quiet();
      rst_n = 1'b1;
      @(negedge bus_clk);
      check_quiet();

      // One key lands in slot 0 with seq 0
      test_name = "single_key";
      press_key(8'h5a);
      wait_records(1);
      host_acquire();
      read_slots(0, 1);
      host_release();

      // Six keys with random gaps wrap the ring
      test_name = "key_burst";
      for (int i = 0; i < 6; i++)
      begin
         rng = xorshift(rng);
         press_key(rng[7:0]);
         repeat (4 + int'(rng[11:8] % 4'd12)) @(negedge bus_clk);
      end
      wait_records(7);
      host_acquire();
      read_slots(0, KBD_SLOTS);
      host_release();

      // Back to back strobes while the host owns the bus
      test_name  = "overflow";
      host_acquire();
      base_dones = done_count;
      drops      = 0;
      key_valid  = 1'b1;
      for (int i = 0; i < 6; i++)
      begin
         rng      = xorshift(rng);
         key_code = rng[7:0];
         @(negedge bus_clk);
         drops += int'(key_drop);
      end
      key_valid = 1'b0;
      // Host keeps the bus for longer than one record takes
      repeat (12)
      begin
         @(negedge bus_clk);
         drops += int'(key_drop);
      end
      if (drops != 6 - QUEUE_DEPTH)
      begin
         tb_errors++;
         $display("FAIL %0s key_drop pulses expected %0d actual %0d", test_name,
                  6 - QUEUE_DEPTH, drops);
      end
      check_bit("records_while_host_owns", 1'b0, done_count != base_dones);
      host_release();
      wait_records(base_dones + QUEUE_DEPTH);
      host_acquire();
      read_slots(0, KBD_SLOTS);
      host_release();

      // Both masters request in one cycle, keyboard goes first
      test_name = "arbitration";
      press_key(8'ha5);
      @(negedge bus_clk);
      host_br   = 1'b1;
      seen_done = 1'b0;
      t         = 0;
      while (!host_bg && t < TIMEOUT)
      begin
         @(negedge bus_clk);
         seen_done = seen_done | kbd_done;
         t++;
      end
      if (!host_bg)
         timeout_error("host_bg after the keyboard record");
      check_bit("kbd_done_before_host_bg", 1'b1, seen_done);
      read_slots(3, 1);
      host_release();

      // Host already granted finishes before the record starts
      host_acquire();
      base_dones = done_count;
      press_key(8'h3c);
      // Two slots keep the host on the bus past one record length
      read_slots(0, 2);
      check_bit("record_during_host_read", 1'b0, done_count != base_dones);
      host_release();
      wait_records(base_dones + 1);
      host_acquire();
      read_slots(0, 1);
      host_release();

      // Reset while a record is requested, then restart at seq 0
      test_name = "reset";
      press_key(8'h77);
      @(negedge bus_clk);
      rst_n = 1'b0;
      repeat (3) @(negedge bus_clk);
      check_quiet();
      rst_n = 1'b1;
      @(negedge bus_clk);
      base_dones = done_count;
      press_key(8'h42);
      wait_records(base_dones + 1);
      host_acquire();
      read_slots(0, 1);
      host_release();

      repeat (5) @(negedge bus_clk);
      check_bit("all_host_reads_seen", 1'b1, read_count == reads_issued);
      $display("summary: %0d records, %0d host words, %0d checker errors, %0d tb errors",
               done_count, read_count, err_count, tb_errors);
      if (err_count == 0 && tb_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule
